//--- fc_subsystem.f
common/fc_pkg.sv
hw/fc_settings_decoder.sv
hw/fc_responder/chdr_hdr_parser.sv
hw/fc_responder/fc_framer.sv
hw/fc_responder/flow_control_responder.sv
hw/fc_arbiter.sv
hw/fc_subsystem_top.sv
dv/clk_gen.sv
dv/tb_fc_subsystem.sv

//--- dv/tb_fc_subsystem.sv
// **************************************************
// Testbench for the flow-control subsystem: stimulus,
// reference packet model, checkers and watchdog
// **************************************************
`timescale 1ns/10ps
`default_nettype none

module tb_fc_subsystem;

  import fc_pkg::*;

  localparam int          NUM_CH     = 2;
  localparam logic [7:0]  SR_BASE    = 8'h10;
  localparam int          PERIOD_NS  = 40;
  localparam int          TOTAL_PKTS = 29;
  localparam logic [31:0] SEED       = 32'h02ff_efe3;

  // Beat 0 header, beat 1 time, beat 2 payload
  typedef chdr_beat_t [2:0] fc_pkt_t;

  logic              clk;
  logic              i_reset;
  logic              i_set_stb;
  logic [7:0]        i_set_addr;
  logic [31:0]       i_set_data;
  chdr_beat_t        i_beat [NUM_CH];
  logic [NUM_CH-1:0] i_valid;
  logic [NUM_CH-1:0] o_ready;
  chdr_beat_t        o_beat [NUM_CH];
  logic [NUM_CH-1:0] o_valid;
  logic [NUM_CH-1:0] i_ready;
  chdr_beat_t        o_fc_beat;
  logic              o_fc_valid;
  logic              i_fc_ready;

  // Scoreboard and reference state
  string       test_name;
  chdr_beat_t  exp_data [NUM_CH][$];
  chdr_beat_t  exp_fc [NUM_CH][$];
  logic [31:0] seq_model [NUM_CH];
  logic [11:0] fc_count [NUM_CH];
  logic [31:0] last_sid [NUM_CH];
  logic [63:0] last_time [NUM_CH];
  int          pkt_index;
  logic        fc_in_pkt = 1'b0;
  int          fc_ch = 0;

  clk_gen #(.PERIOD_NS(PERIOD_NS)) i_clk_gen (.o_clk(clk));

  fc_subsystem_top #(
    .NUM_CHANNELS(NUM_CH),
    .SR_BASE     (SR_BASE),
    .USE_TIME    (1'b1)
  ) i_fc_subsystem_top (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_set_stb (i_set_stb),
    .i_set_addr(i_set_addr),
    .i_set_data(i_set_data),
    .i_beat    (i_beat),
    .i_valid   (i_valid),
    .o_ready   (o_ready),
    .o_beat    (o_beat),
    .o_valid   (o_valid),
    .i_ready   (i_ready),
    .o_fc_beat (o_fc_beat),
    .o_fc_valid(o_fc_valid),
    .i_fc_ready(i_fc_ready)
  );

  // Expected flow-control packet with the sid halves swapped
  function automatic fc_pkt_t fc_reference(logic [31:0] sid, logic [63:0] vtime,
                                           logic [31:0] seq_ext, logic [11:0] count);
    fc_pkt_t pkt;
    pkt[0].data = {2'b10, 1'b1, 1'b0, count, 16'd24, sid[15:0], sid[31:16]};
    pkt[0].last = 1'b0;
    pkt[1].data = vtime;
    pkt[1].last = 1'b0;
    pkt[2].data = {32'h0, seq_ext};
    pkt[2].last = 1'b1;
    return pkt;
  endfunction

  task automatic fail_run(string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(string field, logic [64:0] expected, logic [64:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("ERROR %s: %s expected %h actual %h",
                         test_name, field, expected, actual));
    end
  endtask

  task automatic apply_reset();
    i_reset <= 1'b1;
    repeat (5) @(posedge clk);
    i_reset <= 1'b0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      seq_model[ch] = '0;
      fc_count[ch]  = '0;
    end
  endtask

  task automatic write_setting(logic [7:0] addr, logic [31:0] data);
    @(posedge clk);
    i_set_stb  <= 1'b1;
    i_set_addr <= addr;
    i_set_data <= data;
    @(posedge clk);
    i_set_stb  <= 1'b0;
    @(posedge clk);
  endtask

  task automatic set_trigger(int ch, bit cyc_en, int cycles, bit pkt_en, int packets);
    write_setting(8'(SR_BASE + 2*ch), {cyc_en, 7'h0, 24'(cycles)});
    write_setting(8'(SR_BASE + 2*ch + 1), {pkt_en, 15'h0, 16'(packets)});
  endtask

  // Holds the beat until the parser takes it and returns on that clock edge
  task automatic send_beat(int ch, chdr_beat_t beat);
    i_beat[ch]  <= beat;
    i_valid[ch] <= 1'b1;
    do begin
      @(negedge clk);
    end while (!o_ready[ch]);
    exp_data[ch].push_back(beat);
    @(posedge clk);
  endtask

  task automatic send_packet(int ch, logic [11:0] seqnum, int nbody);
    chdr_beat_t  beat;
    logic [31:0] sid;
    logic [63:0] vtime;
    sid   = {16'(16'hc000 + ch), 16'(pkt_index)};
    vtime = 64'h0000_0100_0000_0000 + 64'(pkt_index) * 64'h1_0003;
    pkt_index++;
    // Carry into the upper bits when the old count was at FFF
    if (seq_model[ch][11:0] == 12'hfff) begin
      seq_model[ch][31:12] = seq_model[ch][31:12] + 1'b1;
    end
    seq_model[ch][11:0] = seqnum;
    last_sid[ch]  = sid;
    last_time[ch] = vtime;
    @(posedge clk);
    beat.data = {2'b00, 1'b1, 1'b0, seqnum, 16'(8 * (2 + nbody)), sid};
    beat.last = 1'b0;
    send_beat(ch, beat);
    beat.data = vtime;
    send_beat(ch, beat);
    for (int i = 0; i < nbody; i++) begin
      beat.data = {sid, 32'(i)} ^ vtime;
      beat.last = (i == nbody - 1);
      send_beat(ch, beat);
    end
    i_valid[ch] <= 1'b0;
  endtask

  task automatic expect_fc(int ch);
    fc_pkt_t pkt;
    pkt = fc_reference(last_sid[ch], last_time[ch], seq_model[ch], fc_count[ch]);
    fc_count[ch] = fc_count[ch] + 1'b1;
    for (int i = 0; i < 3; i++) begin
      exp_fc[ch].push_back(pkt[i]);
    end
    while (exp_fc[ch].size() != 0) begin
      @(posedge clk);
    end
  endtask

  task automatic drain_channel(int ch);
    while (exp_data[ch].size() != 0) begin
      @(posedge clk);
    end
  endtask

  // Three triggers of two packets each
  task automatic run_triggers(int ch);
    for (int t = 0; t < 3; t++) begin
      send_packet(ch, 12'(2*t), 1 + ch);
      send_packet(ch, 12'(2*t + 1), 2);
      expect_fc(ch);
    end
    drain_channel(ch);
  endtask

  // Random back-pressure on every output
  initial begin : backpressure
    void'($urandom(SEED));
    i_ready    = '0;
    i_fc_ready = 1'b0;
    forever begin
      @(posedge clk);
      i_ready    <= NUM_CH'($urandom) | NUM_CH'($urandom);
      i_fc_ready <= ($urandom % 3) != 0;
    end
  end

  // Pass-through beats are compared half a cycle before they transfer
  always @(negedge clk) begin
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (!i_reset && o_valid[ch] && i_ready[ch]) begin
        if (exp_data[ch].size() == 0) begin
          fail_run($sformatf("channel %0d put out a data beat that was never sent", ch));
        end else begin
          check_value($sformatf("ch%0d data beat", ch), exp_data[ch].pop_front(), o_beat[ch]);
        end
      end
    end
  end

  // Flow-control beats go to the channel named by the swapped sid in the header
  always @(negedge clk) begin : fc_compare
    chdr_beat_t beat;
    if (!i_reset && o_fc_valid && i_fc_ready) begin
      beat = o_fc_beat;
      if (!fc_in_pkt) begin
        fc_ch = int'(beat.data[15:0]) - int'(16'hc000);
      end
      if (fc_ch < 0 || fc_ch >= NUM_CH) begin
        fail_run("flow-control header carries a sid of no known channel");
      end else if (exp_fc[fc_ch].size() == 0) begin
        fail_run($sformatf("unexpected flow-control packet from channel %0d", fc_ch));
      end else begin
        check_value($sformatf("ch%0d fc beat", fc_ch), exp_fc[fc_ch].pop_front(), beat);
        fc_in_pkt = !beat.last;
      end
    end
  end

  initial begin : watchdog
    repeat (TOTAL_PKTS * 200) @(posedge clk);
    fail_run("watchdog timeout, the tests did not finish in time");
  end

  initial begin : stimulus
    i_reset    = 1'b1;
    i_set_stb  = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_valid    = '0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      i_beat[ch] = '0;
    end
    pkt_index = 0;
    apply_reset();

    // Both enables off after reset, so no flow-control traffic here
    test_name = "pass_through";
    fork
      begin
        for (int p = 0; p < 4; p++) begin
          send_packet(0, 12'(p), p + 1);
        end
      end
      begin
        for (int p = 0; p < 4; p++) begin
          send_packet(1, 12'(p), 4 - p);
        end
      end
    join
    drain_channel(0);
    drain_channel(1);

    test_name = "packet_mode";
    set_trigger(0, 1'b0, 0, 1'b1, 3);
    for (int p = 4; p < 7; p++) begin
      send_packet(0, 12'(p), 2);
    end
    expect_fc(0);
    drain_channel(0);

    // The wrap past FFF carries into the upper count of the payload
    test_name = "sequence_wrap";
    set_trigger(0, 1'b0, 0, 1'b1, 4);
    send_packet(0, 12'hffe, 1);
    send_packet(0, 12'hfff, 1);
    send_packet(0, 12'h000, 1);
    send_packet(0, 12'h001, 1);
    expect_fc(0);
    drain_channel(0);

    test_name = "cycle_mode";
    set_trigger(0, 1'b1, 20, 1'b0, 0);
    send_packet(0, 12'h002, 2);
    expect_fc(0);
    drain_channel(0);

    test_name = "disabled";
    set_trigger(0, 1'b0, 0, 1'b0, 0);
    send_packet(0, 12'h003, 2);
    drain_channel(0);
    repeat (100) @(posedge clk);

    // Fresh reset so both framers count from 0
    test_name = "two_channels";
    apply_reset();
    set_trigger(0, 1'b0, 0, 1'b1, 2);
    set_trigger(1, 1'b0, 0, 1'b1, 2);
    fork
      run_triggers(0);
      run_triggers(1);
    join
    repeat (20) @(posedge clk);

    if (exp_fc[0].size() != 0 || exp_fc[1].size() != 0 || fc_in_pkt) begin
      fail_run("flow-control packets still outstanding at the end of the run");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- dv/clk_gen.sv
// **************************************************
// Free-running testbench clock
// **************************************************
`timescale 1ns/10ps
`default_nettype none

module clk_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      o_clk = ~o_clk;
    end
  end

endmodule

`default_nettype wire

//--- hw/fc_subsystem_top.sv
// **************************************************
// Flow-control subsystem top: settings decoder,
// per-channel responders and the output arbiter
// **************************************************
`timescale 1ns/10ps
`default_nettype none

module fc_subsystem_top #(
  parameter int         NUM_CHANNELS = 2,
  parameter logic [7:0] SR_BASE      = 8'h10,
  parameter bit         USE_TIME     = 1'b1
) (
  input  wire logic                    clk,
  input  wire logic                    i_reset,
  input  wire logic                    i_set_stb,
  input  wire logic [7:0]              i_set_addr,
  input  wire logic [31:0]             i_set_data,
  input  wire fc_pkg::chdr_beat_t      i_beat [NUM_CHANNELS],
  input  wire logic [NUM_CHANNELS-1:0] i_valid,
  output logic [NUM_CHANNELS-1:0]      o_ready,
  output fc_pkg::chdr_beat_t           o_beat [NUM_CHANNELS],
  output logic [NUM_CHANNELS-1:0]      o_valid,
  input  wire logic [NUM_CHANNELS-1:0] i_ready,
  output fc_pkg::chdr_beat_t           o_fc_beat,
  output logic                         o_fc_valid,
  input  wire logic                    i_fc_ready
);

  import fc_pkg::*;

  fc_cfg_t                 cfg     [NUM_CHANNELS];
  chdr_beat_t              fc_beat [NUM_CHANNELS];
  logic [NUM_CHANNELS-1:0] fc_valid;
  logic [NUM_CHANNELS-1:0] fc_ready;

  fc_settings_decoder #(
    .NUM_CHANNELS(NUM_CHANNELS),
    .SR_BASE     (SR_BASE)
  ) i_settings_decoder (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_set_stb (i_set_stb),
    .i_set_addr(i_set_addr),
    .i_set_data(i_set_data),
    .o_cfg     (cfg)
  );

  for (genvar k = 0; k < NUM_CHANNELS; k++) begin : g_chan
    flow_control_responder #(.USE_TIME(USE_TIME)) i_responder (
      .clk       (clk),
      .i_reset   (i_reset),
      .i_cfg     (cfg[k]),
      .i_beat    (i_beat[k]),
      .i_valid   (i_valid[k]),
      .o_ready   (o_ready[k]),
      .o_beat    (o_beat[k]),
      .o_valid   (o_valid[k]),
      .i_ready   (i_ready[k]),
      .o_fc_beat (fc_beat[k]),
      .o_fc_valid(fc_valid[k]),
      .i_fc_ready(fc_ready[k])
    );
  end

  fc_arbiter #(.NUM_CHANNELS(NUM_CHANNELS)) i_arbiter (
    .clk    (clk),
    .i_reset(i_reset),
    .i_beat (fc_beat),
    .i_valid(fc_valid),
    .o_ready(fc_ready),
    .o_beat (o_fc_beat),
    .o_valid(o_fc_valid),
    .i_ready(i_fc_ready)
  );

endmodule

`default_nettype wire

//--- hw/fc_arbiter.sv
// **************************************************
// Round-robin merge of the per-channel flow-control
// streams, one whole packet per grant
// **************************************************
`timescale 1ns/10ps
`default_nettype none

module fc_arbiter #(
  parameter int NUM_CHANNELS = 2
) (
  input  wire logic                    clk,
  input  wire logic                    i_reset,
  input  wire fc_pkg::chdr_beat_t      i_beat [NUM_CHANNELS],
  input  wire logic [NUM_CHANNELS-1:0] i_valid,
  output logic [NUM_CHANNELS-1:0]      o_ready,
  output fc_pkg::chdr_beat_t           o_beat,
  output logic                         o_valid,
  input  wire logic                    i_ready
);

  localparam int CH_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

  logic                    locked;
  logic [NUM_CHANNELS-1:0] grant;
  logic [CH_W-1:0]         last_idx;
  logic [NUM_CHANNELS-1:0] pick;
  logic [CH_W-1:0]         pick_idx;
  logic                    found;
  logic                    pkt_done;

  // Search starts one past the channel served last
  always_comb begin : pick_next
    int idx;
    pick     = '0;
    pick_idx = last_idx;
    found    = 1'b0;
    for (int i = 1; i <= NUM_CHANNELS; i++) begin
      idx = (int'(last_idx) + i) % NUM_CHANNELS;
      if (!found && i_valid[idx]) begin
        pick[idx] = 1'b1;
        pick_idx  = CH_W'(idx);
        found     = 1'b1;
      end
    end
  end

  always_comb begin
    o_beat = '0;
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      if (grant[i]) begin
        o_beat = i_beat[i];
      end
    end
  end

  assign o_valid  = locked && |(i_valid & grant);
  assign o_ready  = locked ? (grant & {NUM_CHANNELS{i_ready}}) : '0;
  assign pkt_done = o_valid && i_ready && o_beat.last;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      locked   <= 1'b0;
      grant    <= '0;
      last_idx <= CH_W'(NUM_CHANNELS - 1);
    end else if (!locked) begin
      if (found) begin
        locked   <= 1'b1;
        grant    <= pick;
        last_idx <= pick_idx;
      end
    end else if (pkt_done) begin
      locked <= 1'b0;
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (i_reset)
    locked |-> $onehot(grant));

endmodule

`default_nettype wire

//--- hw/fc_responder/flow_control_responder.sv
// **************************************************
// Flow-control responder: header parse, extended
// sequence count, trigger counters and FC framing
// **************************************************
`timescale 1ns/10ps
`default_nettype none

module flow_control_responder #(
  parameter bit USE_TIME = 1'b1
) (
  input  wire logic               clk,
  input  wire logic               i_reset,
  input  wire fc_pkg::fc_cfg_t    i_cfg,
  input  wire fc_pkg::chdr_beat_t i_beat,
  input  wire logic               i_valid,
  output logic                    o_ready,
  output fc_pkg::chdr_beat_t      o_beat,
  output logic                    o_valid,
  input  wire logic               i_ready,
  output fc_pkg::chdr_beat_t      o_fc_beat,
  output logic                    o_fc_valid,
  input  wire logic               i_fc_ready
);

  import fc_pkg::*;

  chdr_hdr_t         hdr;
  logic              hdr_stb;
  logic [DATA_W-1:0] vita_time;
  logic [31:0]       sid_q;
  logic [31:0]       seq_ext;
  logic [16:0]       pkt_cnt;
  logic [24:0]       cyc_cnt;
  logic              consumed;
  logic              trigger;
  fc_req_t           req;
  logic              req_valid;
  logic              req_ready;

  chdr_hdr_parser i_parser (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_beat     (i_beat),
    .i_valid    (i_valid),
    .o_ready    (o_ready),
    .o_beat     (o_beat),
    .o_valid    (o_valid),
    .i_ready    (i_ready),
    .o_hdr_stb  (hdr_stb),
    .o_hdr      (hdr),
    .o_vita_time(vita_time)
  );

  assign consumed = o_valid && i_ready && o_beat.last;

  // Extend the 12-bit header count, carry on a wrap past FFF
  always_ff @(posedge clk) begin
    if (i_reset) begin
      seq_ext <= '0;
    end else if (hdr_stb) begin
      seq_ext[SEQ_W-1:0] <= hdr.seqnum;
      if (seq_ext[SEQ_W-1:0] == '1) begin
        seq_ext[31:SEQ_W] <= seq_ext[31:SEQ_W] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_stb) begin
      sid_q <= hdr.sid;
    end
  end

  // Cycle trigger only counts once a consumed packet started it
  assign trigger = (i_cfg.pkt_en && (pkt_cnt >= {1'b0, i_cfg.packets})) ||
                   (i_cfg.cyc_en && (cyc_cnt != '0) && (cyc_cnt >= {1'b0, i_cfg.cycles}));

  always_ff @(posedge clk) begin
    if (i_reset) begin
      pkt_cnt   <= '0;
      cyc_cnt   <= '0;
      req_valid <= 1'b0;
    end else if (req_valid) begin
      // Counters frozen until the framer takes the request
      if (req_ready) begin
        req_valid <= 1'b0;
        pkt_cnt   <= '0;
        cyc_cnt   <= '0;
      end
    end else begin
      if (i_cfg.pkt_en && consumed) begin
        pkt_cnt <= pkt_cnt + 1'b1;
      end
      if (i_cfg.cyc_en && (consumed || (cyc_cnt != '0))) begin
        cyc_cnt <= cyc_cnt + 1'b1;
      end
      if (trigger) begin
        req_valid <= 1'b1;
      end
    end
  end

  // Snapshot taken when the request is raised
  always_ff @(posedge clk) begin
    if (!req_valid && trigger) begin
      req.sid       <= sid_q;
      req.vita_time <= vita_time;
      req.seq_ext   <= seq_ext;
    end
  end

  fc_framer #(.USE_TIME(USE_TIME)) i_framer (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_req      (req),
    .i_req_valid(req_valid),
    .o_req_ready(req_ready),
    .o_beat     (o_fc_beat),
    .o_valid    (o_fc_valid),
    .i_ready    (i_fc_ready)
  );

endmodule

`default_nettype wire

//--- hw/fc_responder/fc_framer.sv
// **************************************************
// Flow-control packet framer with its own packet
// sequence counter
// **************************************************
`timescale 1ns/10ps
`default_nettype none

module fc_framer #(
  parameter bit USE_TIME = 1'b1
) (
  input  wire logic               clk,
  input  wire logic               i_reset,
  input  wire fc_pkg::fc_req_t    i_req,
  input  wire logic               i_req_valid,
  output logic                    o_req_ready,
  output fc_pkg::chdr_beat_t      o_beat,
  output logic                    o_valid,
  input  wire logic               i_ready
);

  import fc_pkg::*;

  typedef enum logic [1:0] {
    B_HDR,
    B_TIME,
    B_PAYLOAD
  } beat_idx_t;

  // 8 bytes per beat, the time beat is optional
  localparam logic [15:0] PKT_LEN = USE_TIME ? 16'd24 : 16'd16;

  beat_idx_t        idx;
  fc_req_t          req_q;
  logic [SEQ_W-1:0] seq_q;
  chdr_hdr_t        hdr;

  // One packet at a time
  assign o_req_ready = !o_valid;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
      idx     <= B_HDR;
      seq_q   <= '0;
    end else if (i_req_valid && o_req_ready) begin
      o_valid <= 1'b1;
      idx     <= B_HDR;
    end else if (o_valid && i_ready) begin
      case (idx)
        B_HDR:   idx <= USE_TIME ? B_TIME : B_PAYLOAD;
        B_TIME:  idx <= B_PAYLOAD;
        default: begin
          o_valid <= 1'b0;
          idx     <= B_HDR;
          seq_q   <= seq_q + 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_req_valid && o_req_ready) begin
      req_q <= i_req;
    end
  end

  always_comb begin
    hdr.pkt_type = FC_PKT_TYPE;
    hdr.has_time = USE_TIME;
    hdr.eob      = 1'b0;
    hdr.seqnum   = seq_q;
    hdr.length   = PKT_LEN;
    // Reply goes back to the sender, so source and destination swap
    hdr.sid      = {req_q.sid[15:0], req_q.sid[31:16]};
    case (idx)
      B_HDR: begin
        o_beat.data = hdr;
        o_beat.last = 1'b0;
      end
      B_TIME: begin
        o_beat.data = req_q.vita_time;
        o_beat.last = 1'b0;
      end
      default: begin
        o_beat.data = {32'h0, req_q.seq_ext};
        o_beat.last = 1'b1;
      end
    endcase
  end

  a_beat_stable: assert property (@(posedge clk) disable iff (i_reset)
    o_valid && !i_ready |=> o_valid && $stable(o_beat));

endmodule

`default_nettype wire

//--- hw/fc_responder/chdr_hdr_parser.sv
// **************************************************
// One-deep registered stream stage that decodes the
// CHDR header and captures the time beat
// **************************************************
`timescale 1ns/10ps
`default_nettype none

module chdr_hdr_parser (
  input  wire logic                  clk,
  input  wire logic                  i_reset,
  input  wire fc_pkg::chdr_beat_t    i_beat,
  input  wire logic                  i_valid,
  output logic                       o_ready,
  output fc_pkg::chdr_beat_t         o_beat,
  output logic                       o_valid,
  input  wire logic                  i_ready,
  output logic                       o_hdr_stb,
  output fc_pkg::chdr_hdr_t          o_hdr,
  output logic [fc_pkg::DATA_W-1:0]  o_vita_time
);

  import fc_pkg::*;

  // Position of the next beat accepted at the input
  typedef enum logic [1:0] {
    POS_HDR,
    POS_TIME,
    POS_BODY
  } pos_t;

  pos_t pos;
  logic in_xfer;

  // Stage can take a beat when empty or draining this cycle
  assign o_ready = !o_valid || i_ready;
  assign in_xfer = i_valid && o_ready;

  // Header fields come straight off the input beat
  assign o_hdr     = chdr_hdr_t'(i_beat.data);
  assign o_hdr_stb = in_xfer && (pos == POS_HDR);

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
      pos     <= POS_HDR;
    end else begin
      if (o_ready) begin
        o_valid <= i_valid;
      end
      if (in_xfer) begin
        if (i_beat.last) begin
          pos <= POS_HDR;
        end else if (pos == POS_HDR) begin
          pos <= o_hdr.has_time ? POS_TIME : POS_BODY;
        end else begin
          pos <= POS_BODY;
        end
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (in_xfer) begin
      o_beat <= i_beat;
    end
    if (in_xfer && (pos == POS_TIME)) begin
      o_vita_time <= i_beat.data;
    end
  end

  a_out_stable: assert property (@(posedge clk) disable iff (i_reset)
    o_valid && !i_ready |=> o_valid && $stable(o_beat));

endmodule

`default_nettype wire

//--- hw/fc_settings_decoder.sv
// **************************************************
// Settings bus decoder, one cycle word and one packet
// word register per channel
// **************************************************
`timescale 1ns/10ps
`default_nettype none

module fc_settings_decoder #(
  parameter int         NUM_CHANNELS = 2,
  parameter logic [7:0] SR_BASE      = 8'h10
) (
  input  wire logic        clk,
  input  wire logic        i_reset,
  input  wire logic        i_set_stb,
  input  wire logic [7:0]  i_set_addr,
  input  wire logic [31:0] i_set_data,
  output fc_pkg::fc_cfg_t  o_cfg [NUM_CHANNELS]
);

  import fc_pkg::*;

  sr_word_u                  word;
  logic [2*NUM_CHANNELS-1:0] hit;

  assign word = i_set_data;

  for (genvar k = 0; k < NUM_CHANNELS; k++) begin : g_chan
    localparam logic [7:0] CYC_ADDR = 8'(SR_BASE + 2*k);
    localparam logic [7:0] PKT_ADDR = 8'(SR_BASE + 2*k + 1);

    assign hit[2*k]   = i_set_stb && (i_set_addr == CYC_ADDR);
    assign hit[2*k+1] = i_set_stb && (i_set_addr == PKT_ADDR);

    always_ff @(posedge clk) begin
      if (i_reset) begin
        o_cfg[k] <= '0;
      end else begin
        if (hit[2*k]) begin
          o_cfg[k].cyc_en <= word.cyc.enable;
          o_cfg[k].cycles <= word.cyc.cycles;
        end
        if (hit[2*k+1]) begin
          o_cfg[k].pkt_en  <= word.pkt.enable;
          o_cfg[k].packets <= word.pkt.packets;
        end
      end
    end
  end

  // Slot addresses must not alias, e.g. when SR_BASE plus the channel range wraps
  a_single_slot: assert property (@(posedge clk) disable iff (i_reset)
    i_set_stb |-> $onehot0(hit));

endmodule

`default_nettype wire

//--- common/fc_pkg.sv
// **************************************************
// Shared widths, stream beat and CHDR header layout,
// settings word views and the flow-control request
// **************************************************
`default_nettype none

package fc_pkg;

  localparam int DATA_W = 64;
  localparam int SEQ_W  = 12;

  // Packet type of every flow-control packet
  localparam logic [1:0] FC_PKT_TYPE = 2'b10;

  // One stream beat
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } chdr_beat_t;

  // First beat of a CHDR packet, MSB first
  typedef struct packed {
    logic [1:0]       pkt_type;
    logic             has_time;
    logic             eob;
    logic [SEQ_W-1:0] seqnum;
    logic [15:0]      length;
    logic [31:0]      sid;
  } chdr_hdr_t;

  // Per-channel trigger configuration
  typedef struct packed {
    logic        cyc_en;
    logic [23:0] cycles;
    logic        pkt_en;
    logic [15:0] packets;
  } fc_cfg_t;

  typedef struct packed {
    logic        enable;
    logic [6:0]  rsvd;
    logic [23:0] cycles;
  } sr_cyc_t;

  typedef struct packed {
    logic        enable;
    logic [14:0] rsvd;
    logic [15:0] packets;
  } sr_pkt_t;

  // Settings word, read as cycle word or packet word by address
  typedef union packed {
    sr_cyc_t cyc;
    sr_pkt_t pkt;
  } sr_word_u;

  // Request from the trigger logic to the framer
  typedef struct packed {
    logic [31:0]       sid;
    logic [DATA_W-1:0] vita_time;
    logic [31:0]       seq_ext;
  } fc_req_t;

endpackage

`default_nettype wire
